/* dv/fe_imem_model.sv */
// wishbone classic read slave, one transfer at a time, no writes
// ack or err comes 1 to 4 cycles after stb is first seen; addresses from 0x8000_0000 give err
module fe_imem_model
  (
  input  logic        clk_i,
  input  logic        reset_i,
  input  logic        wb_cyc_i,
  input  logic        wb_stb_i,
  input  logic [31:0] wb_adr_i,
  output logic [63:0] wb_dat_o,
  output logic        wb_ack_o,
  output logic        wb_err_o
  );
  timeunit 1ns;
  timeprecision 1ps;

  localparam logic [6:0]  OPC_ADDI  = 7'b0010011;
  localparam logic [15:0] LFSR_SEED = 16'd25792;
  localparam logic [31:0] ERR_BASE  = 32'h8000_0000;

  logic [15:0] lfsr_r   = LFSR_SEED;
  logic [15:0] lfsr_1;
  logic [15:0] lfsr_2;
  logic        active_r = 1'b0;
  logic [1:0]  wait_r   = 2'd0;
  logic [63:0] dat_r    = '0;
  logic        ack_r    = 1'b0;
  logic        err_r    = 1'b0;

  // galois lfsr, one step per bit taken
  function automatic logic [15:0] lfsr_step(input logic [15:0] s);
    if (s[0])
      lfsr_step = (s >> 1) ^ 16'hB400;
    else
      lfsr_step = s >> 1;
  endfunction

  // address tag in the upper bits, branch in the lower word of 0x400..0x4ff bundles
  function automatic logic [31:0] word_at(input logic [31:0] addr);
    logic [24:0] tag;
    tag = addr[31:7] ^ addr[24:0];
    if (addr >= 32'h400 && addr <= 32'h4FF && addr[2] == 1'b0)
      word_at = {tag, fe_pkg::OPC_BRANCH};
    else
      word_at = {tag, OPC_ADDI};
  endfunction

  // two fresh bits per request pick the wait count
  assign lfsr_1 = lfsr_step(lfsr_r);
  assign lfsr_2 = lfsr_step(lfsr_1);

  assign wb_dat_o = dat_r;
  assign wb_ack_o = ack_r;
  assign wb_err_o = err_r;

  always @(posedge clk_i)
  begin
    if (reset_i)
    begin
      active_r <= 1'b0;
      ack_r    <= 1'b0;
      err_r    <= 1'b0;
      wait_r   <= 2'd0;
      lfsr_r   <= LFSR_SEED;
    end
    else if (ack_r | err_r)
    begin
      // response lasts one cycle, master drops stb after it
      ack_r    <= 1'b0;
      err_r    <= 1'b0;
      active_r <= 1'b0;
    end
    else if (wb_cyc_i & wb_stb_i & ~active_r)
    begin
      active_r <= 1'b1;
      wait_r   <= {lfsr_1[0], lfsr_2[0]};
      lfsr_r   <= lfsr_2;
    end
    else if (active_r)
    begin
      if (wait_r != 2'd0)
        wait_r <= wait_r - 2'd1;
      else if (wb_adr_i >= ERR_BASE)
        err_r <= 1'b1;
      else
      begin
        ack_r <= 1'b1;
        dat_r <= {word_at(wb_adr_i + 32'd4), word_at(wb_adr_i)};
      end
    end
  end

endmodule

/* dv/tb_fe_top.sv */
// directed tests for the fetch front end against a random-latency memory model
// lane transfers are recorded at the rising edge; inputs change on the falling edge
module tb_fe_top;
  timeunit 1ns;
  timeprecision 1ps;

  localparam int CLK_HALF     = 20;
  localparam int RESET_CYCLES = 10;
  // six tests of about 60 bundles; a bundle with ready stalls stays well under 56 cycles
  localparam int TEST_CNT          = 6;
  localparam int BUNDLES_PER_TEST  = 60;
  localparam int CYCLES_PER_BUNDLE = 56;
  localparam int TIMEOUT_CYCLES    = TEST_CNT * BUNDLES_PER_TEST * CYCLES_PER_BUNDLE;
  localparam logic [6:0]  OPC_ADDI  = 7'b0010011;
  localparam logic [15:0] LFSR_SEED = 16'd25792;
  // ready driver modes
  localparam int READY_LOW    = 0;
  localparam int READY_HIGH   = 1;
  localparam int READY_RANDOM = 2;

  logic                        clk = 1'b0;
  logic                        reset;
  logic                        cmd_v;
  logic [fe_pkg::CMD_W-1:0]    cmd_op;
  logic [fe_pkg::VADDR_W-1:0]  cmd_vaddr;
  logic                        cmd_yumi;
  logic                        wb_cyc;
  logic                        wb_stb;
  logic [fe_pkg::VADDR_W-1:0]  wb_adr;
  logic [fe_pkg::BUNDLE_W-1:0] wb_dat;
  logic                        wb_ack;
  logic                        wb_err;
  logic [fe_pkg::QUEUE_W-1:0]  q1;
  logic [fe_pkg::QUEUE_W-1:0]  q2;
  logic                        q1_type;
  logic                        q1_v;
  logic                        q2_type;
  logic                        q2_v;
  logic                        queue_ready = 1'b0;

  // transfer log, one element per handshake
  logic [fe_pkg::QUEUE_W-1:0] rec_q1 [$];
  logic                       rec_q1_type [$];
  logic [fe_pkg::QUEUE_W-1:0] rec_q2 [$];
  logic                       rec_q2_v [$];
  logic                       rec_q2_type [$];

  int          bus_starts = 0;
  logic        cyc_prev   = 1'b0;
  int          cycle_cnt  = 0;
  int          err_cnt;
  int          check_cnt;
  int          test_cnt;
  int          ready_mode;
  logic [15:0] lfsr = LFSR_SEED;

  fe_top i_dut
    (
    .clk_i            (clk),
    .reset_i          (reset),
    .fe_cmd_v_i       (cmd_v),
    .fe_cmd_op_i      (cmd_op),
    .fe_cmd_vaddr_i   (cmd_vaddr),
    .fe_cmd_yumi_o    (cmd_yumi),
    .wb_cyc_o         (wb_cyc),
    .wb_stb_o         (wb_stb),
    .wb_adr_o         (wb_adr),
    .wb_dat_i         (wb_dat),
    .wb_ack_i         (wb_ack),
    .wb_err_i         (wb_err),
    .fe_queue1_o      (q1),
    .fe_queue1_type_o (q1_type),
    .fe_queue1_v_o    (q1_v),
    .fe_queue2_o      (q2),
    .fe_queue2_type_o (q2_type),
    .fe_queue2_v_o    (q2_v),
    .fe_queue_ready_i (queue_ready)
    );

  fe_imem_model i_mem
    (
    .clk_i    (clk),
    .reset_i  (reset),
    .wb_cyc_i (wb_cyc),
    .wb_stb_i (wb_stb),
    .wb_adr_i (wb_adr),
    .wb_dat_o (wb_dat),
    .wb_ack_o (wb_ack),
    .wb_err_o (wb_err)
    );

  initial
  begin
    forever #CLK_HALF clk = ~clk;
  end

  function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    if (s[0])
      lfsr_next = (s >> 1) ^ 16'hB400;
    else
      lfsr_next = s >> 1;
  endfunction

  function automatic logic in_branch_region(input logic [31:0] addr);
    in_branch_region = (addr >= 32'h400) && (addr <= 32'h4FF);
  endfunction

  // expected memory word from the fill rule
  function automatic logic [31:0] mem_word(input logic [31:0] addr);
    logic [24:0] tag;
    tag = addr[31:7] ^ addr[24:0];
    if (in_branch_region(addr) && addr[2] == 1'b0)
      mem_word = {tag, fe_pkg::OPC_BRANCH};
    else
      mem_word = {tag, OPC_ADDI};
  endfunction

  // ready back-pressure, one lfsr bit per cycle in random mode
  always @(negedge clk)
  begin
    if (ready_mode == READY_RANDOM)
    begin
      lfsr = lfsr_next(lfsr);
      queue_ready <= lfsr[0];
    end
    else
      queue_ready <= (ready_mode == READY_HIGH);
  end

  // lane and bus monitor
  always @(posedge clk)
  begin
    cycle_cnt = cycle_cnt + 1;
    if (!reset)
    begin
      if (q1_v && queue_ready)
      begin
        rec_q1.push_back(q1);
        rec_q1_type.push_back(q1_type);
        rec_q2.push_back(q2);
        rec_q2_v.push_back(q2_v);
        rec_q2_type.push_back(q2_type);
      end
      // classic bus, stb travels with cyc
      check_value("bus", "stb with cyc", 64'(wb_cyc), 64'(wb_stb));
      if (wb_cyc && !cyc_prev)
        bus_starts = bus_starts + 1;
    end
    cyc_prev = wb_cyc;
  end

  initial
  begin
    while (cycle_cnt < TIMEOUT_CYCLES)
      @(posedge clk);
    $display("timeout: tests still running after %0d cycles", TIMEOUT_CYCLES);
    $display("TB FAILED");
    $finish;
  end

  task automatic check_value(input string test, input string what,
                             input logic [63:0] exp, input logic [63:0] act);
    check_cnt = check_cnt + 1;
    if (exp !== act)
    begin
      err_cnt = err_cnt + 1;
      $display("ERR %s %s: expected %h actual %h", test, what, exp, act);
    end
  endtask

  task automatic report_test(input string name, input int errs_before);
    test_cnt = test_cnt + 1;
    $display("test %s finished, %0d errors", name, err_cnt - errs_before);
  endtask

  task automatic wait_cycles(input int n);
    repeat (n) @(negedge clk);
  endtask

  task automatic wait_transfers(input int n);
    while (rec_q1.size() < n)
      @(negedge clk);
  endtask

  // hold the command until the fetch unit takes it
  task automatic send_cmd(input logic [1:0] op, input logic [31:0] addr);
    @(negedge clk);
    cmd_v     = 1'b1;
    cmd_op    = op;
    cmd_vaddr = addr;
    #1;
    while (!cmd_yumi)
    begin
      @(negedge clk);
      #1;
    end
    @(negedge clk);
    cmd_v = 1'b0;
  endtask

  // no lane valid and no bus cycle for 8 cycles in a row
  task automatic wait_quiet();
    int quiet;
    quiet = 0;
    while (quiet < 8)
    begin
      @(negedge clk);
      if (q1_v || wb_cyc)
        quiet = 0;
      else
        quiet = quiet + 1;
    end
  endtask

  task automatic stop_fetch();
    send_cmd(fe_pkg::CMD_WAIT, 32'h0);
    ready_mode = READY_HIGH;
    wait_quiet();
  endtask

  task automatic clear_records();
    rec_q1.delete();
    rec_q1_type.delete();
    rec_q2.delete();
    rec_q2_v.delete();
    rec_q2_type.delete();
  endtask

  // k-th transfer must be the bundle at start+8k with both words from memory
  task automatic check_stream(input string test, input logic [31:0] start);
    fe_pkg::fe_queue_entry_u l1;
    fe_pkg::fe_queue_entry_u l2;
    logic [31:0] pc;
    int k;
    for (k = 0; k < rec_q1.size(); k++)
    begin
      pc = start + 32'(k * 8);
      l1 = rec_q1[k];
      l2 = rec_q2[k];
      check_value(test, "lane1 type", 64'(fe_pkg::MSG_FETCH), 64'(rec_q1_type[k]));
      check_value(test, "lane1 pc", 64'(pc), 64'(l1.fetch.pc));
      check_value(test, "lane1 instr", 64'(mem_word(pc)), 64'(l1.fetch.instr));
      // branch in lane 1 squashes lane 2
      check_value(test, "lane2 valid", 64'(!in_branch_region(pc)), 64'(rec_q2_v[k]));
      if (rec_q2_v[k])
      begin
        check_value(test, "lane2 type", 64'(fe_pkg::MSG_FETCH), 64'(rec_q2_type[k]));
        check_value(test, "lane2 pc", 64'(pc + 32'd4), 64'(l2.fetch.pc));
        check_value(test, "lane2 instr", 64'(mem_word(pc + 32'd4)), 64'(l2.fetch.instr));
      end
    end
  endtask

  task automatic idle_after_reset();
    int errs0;
    errs0 = err_cnt;
    ready_mode = READY_HIGH;
    repeat (30)
    begin
      @(negedge clk);
      check_value("idle", "lane1 valid", 64'(0), 64'(q1_v));
      check_value("idle", "lane2 valid", 64'(0), 64'(q2_v));
      check_value("idle", "wb cyc", 64'(0), 64'(wb_cyc));
      check_value("idle", "cmd yumi", 64'(0), 64'(cmd_yumi));
    end
    check_value("idle", "bus cycles", 64'(0), 64'(bus_starts));
    report_test("idle", errs0);
  endtask

  task automatic sequential_fetch();
    int errs0;
    errs0 = err_cnt;
    clear_records();
    ready_mode = READY_RANDOM;
    send_cmd(fe_pkg::CMD_REDIRECT, 32'h100);
    wait_transfers(BUNDLES_PER_TEST);
    stop_fetch();
    check_stream("sequential", 32'h100);
    report_test("sequential", errs0);
  endtask

  task automatic branch_squash();
    int errs0;
    errs0 = err_cnt;
    clear_records();
    ready_mode = READY_HIGH;
    send_cmd(fe_pkg::CMD_REDIRECT, 32'h400);
    wait_transfers(16);
    stop_fetch();
    // 0x400..0x4ff holds 32 bundles
    check_value("branch", "stays in region", 64'(1), 64'(rec_q1.size() <= 32));
    check_stream("branch", 32'h400);
    report_test("branch", errs0);
  endtask

  // a single exception entry on lane 1, then nothing
  task automatic fault_entry(input string name, input logic [31:0] addr,
                             input logic [3:0] code, input int bus_cycles);
    fe_pkg::fe_queue_entry_u l1;
    int errs0;
    int starts0;
    errs0 = err_cnt;
    clear_records();
    ready_mode = READY_HIGH;
    starts0 = bus_starts;
    send_cmd(fe_pkg::CMD_REDIRECT, addr);
    wait_transfers(1);
    wait_cycles(30);
    l1 = rec_q1[0];
    check_value(name, "entry count", 64'(1), 64'(rec_q1.size()));
    check_value(name, "lane1 type", 64'(fe_pkg::MSG_EXCEPTION), 64'(rec_q1_type[0]));
    check_value(name, "vaddr", 64'(addr), 64'(l1.exc.vaddr));
    check_value(name, "code", 64'(code), 64'(l1.exc.code));
    check_value(name, "lane2 valid", 64'(0), 64'(rec_q2_v[0]));
    check_value(name, "bus cycles", 64'(bus_cycles), 64'(bus_starts - starts0));
    report_test(name, errs0);
  endtask

  task automatic redirect_flush();
    int errs0;
    int starts0;
    errs0 = err_cnt;
    clear_records();
    ready_mode = READY_LOW;
    starts0 = bus_starts;
    send_cmd(fe_pkg::CMD_REDIRECT, 32'h200);
    while (bus_starts < starts0 + fe_pkg::FIFO_DEPTH || wb_cyc)
      @(negedge clk);
    wait_cycles(20);
    // full buffer and ready low: no bus cycle, lane 1 held on the first bundle
    check_value("flush", "bus cycles while full", 64'(starts0 + fe_pkg::FIFO_DEPTH),
                64'(bus_starts));
    check_value("flush", "lane1 held valid", 64'(1), 64'(q1_v));
    check_value("flush", "lane1 held pc", 64'(32'h200), 64'(q1[63:32]));
    send_cmd(fe_pkg::CMD_REDIRECT, 32'h300);
    wait_cycles(10);
    ready_mode = READY_HIGH;
    wait_transfers(12);
    starts0 = bus_starts;
    send_cmd(fe_pkg::CMD_WAIT, 32'h0);
    wait_quiet();
    check_value("flush", "reads after wait", 64'(1), 64'(bus_starts - starts0 <= 1));
    check_stream("flush", 32'h300);
    report_test("flush", errs0);
  endtask

  initial
  begin
    reset      = 1'b1;
    cmd_v      = 1'b0;
    cmd_op     = '0;
    cmd_vaddr  = '0;
    ready_mode = READY_LOW;
    err_cnt    = 0;
    check_cnt  = 0;
    test_cnt   = 0;
    repeat (RESET_CYCLES) @(posedge clk);
    @(negedge clk);
    reset = 1'b0;
    idle_after_reset();
    sequential_fetch();
    branch_squash();
    fault_entry("misaligned", 32'h104, fe_pkg::EXC_MISALIGNED, 0);
    fault_entry("access_fault", 32'h8000_0000, fe_pkg::EXC_ACCESS_FAULT, 1);
    redirect_flush();
    $display("summary: %0d tests, %0d checks, %0d errors", test_cnt, check_cnt, err_cnt);
    if (err_cnt == 0)
      $display("TB PASSED");
    else
      $display("TB FAILED");
    $finish;
  end

endmodule

/* logic/fe_fetch_fifo.sv */
// circular buffer with head shown combinationally; pushes while full are dropped
// flush clears old entries, a push in the same cycle becomes the only entry
module fe_fetch_fifo
  (
  input  logic                        clk_i,
  input  logic                        reset_i,
  input  logic                        flush_i,
  input  logic                        push_v_i,
  input  logic [fe_pkg::VADDR_W-1:0]  push_pc_i,
  input  logic [fe_pkg::BUNDLE_W-1:0] push_bundle_i,
  input  logic                        push_exc_v_i,
  input  logic [fe_pkg::EXC_W-1:0]    push_exc_code_i,
  input  logic                        pop_i,
  output logic                        full_o,
  output logic                        head_v_o,
  output logic [fe_pkg::VADDR_W-1:0]  head_pc_o,
  output logic [fe_pkg::BUNDLE_W-1:0] head_bundle_o,
  output logic                        head_exc_v_o,
  output logic [fe_pkg::EXC_W-1:0]    head_exc_code_o
  );

  // entry storage
  logic [fe_pkg::VADDR_W-1:0]  pc_mem     [fe_pkg::FIFO_DEPTH];
  logic [fe_pkg::BUNDLE_W-1:0] bundle_mem [fe_pkg::FIFO_DEPTH];
  logic                        exc_v_mem  [fe_pkg::FIFO_DEPTH];
  logic [fe_pkg::EXC_W-1:0]    exc_mem    [fe_pkg::FIFO_DEPTH];

  logic [fe_pkg::FIFO_PTR_W-1:0] rd_ptr_r;
  logic [fe_pkg::FIFO_PTR_W-1:0] wr_ptr_r;
  logic [fe_pkg::FIFO_PTR_W-1:0] wr_addr;
  logic [fe_pkg::FIFO_PTR_W:0]   count_r;
  logic                          wr_en;
  logic                          rd_en;

  assign full_o   = (count_r == (fe_pkg::FIFO_PTR_W+1)'(fe_pkg::FIFO_DEPTH));
  assign head_v_o = (count_r != '0);

  // flush frees the whole buffer, so a push then always fits
  assign wr_en   = push_v_i & (flush_i | ~full_o);
  assign rd_en   = pop_i & head_v_o & ~flush_i;
  assign wr_addr = flush_i ? '0 : wr_ptr_r;

  // head entry
  assign head_pc_o       = pc_mem[rd_ptr_r];
  assign head_bundle_o   = bundle_mem[rd_ptr_r];
  assign head_exc_v_o    = exc_v_mem[rd_ptr_r];
  assign head_exc_code_o = exc_mem[rd_ptr_r];

  always_ff @(posedge clk_i)
  begin
    if (reset_i)
    begin
      rd_ptr_r <= '0;
      wr_ptr_r <= '0;
      count_r  <= '0;
    end
    else if (flush_i)
    begin
      rd_ptr_r <= '0;
      wr_ptr_r <= (fe_pkg::FIFO_PTR_W)'(wr_en);
      count_r  <= (fe_pkg::FIFO_PTR_W+1)'(wr_en);
    end
    else
    begin
      // pointers wrap on their own, depth is a power of two
      if (wr_en)
        wr_ptr_r <= wr_ptr_r + 1'b1;
      if (rd_en)
        rd_ptr_r <= rd_ptr_r + 1'b1;
      if (wr_en & ~rd_en)
        count_r <= count_r + 1'b1;
      else if (rd_en & ~wr_en)
        count_r <= count_r - 1'b1;
    end
  end

  // payload write
  always_ff @(posedge clk_i)
  begin
    if (wr_en)
    begin
      pc_mem[wr_addr]     <= push_pc_i;
      bundle_mem[wr_addr] <= push_bundle_i;
      exc_v_mem[wr_addr]  <= push_exc_v_i;
      exc_mem[wr_addr]    <= push_exc_code_i;
    end
  end

endmodule

/* logic/fe_instr_scan.sv */
// splits the head bundle onto two lanes; purely combinational
// lane 2 is squashed behind a branch, jal or jalr, and behind any exception
module fe_instr_scan
  (
  input  logic                        head_v_i,
  input  logic [fe_pkg::VADDR_W-1:0]  head_pc_i,
  input  logic [fe_pkg::BUNDLE_W-1:0] head_bundle_i,
  input  logic                        head_exc_v_i,
  input  logic [fe_pkg::EXC_W-1:0]    head_exc_code_i,
  input  logic                        fe_queue_ready_i,
  output logic                        pop_o,
  output logic [fe_pkg::QUEUE_W-1:0]  fe_queue1_o,
  output logic                        fe_queue1_type_o,
  output logic                        fe_queue1_v_o,
  output logic [fe_pkg::QUEUE_W-1:0]  fe_queue2_o,
  output logic                        fe_queue2_type_o,
  output logic                        fe_queue2_v_o
  );

  fe_pkg::fe_queue_entry_u   lane1;
  fe_pkg::fe_queue_entry_u   lane2;
  logic [fe_pkg::INSTR_W-1:0] instr_lo;
  logic [fe_pkg::INSTR_W-1:0] instr_hi;
  logic [fe_pkg::OPC_W-1:0]   opc_lo;
  logic                       is_ctrl;

  // lower word sits at the bundle pc
  assign instr_lo = head_bundle_i[fe_pkg::INSTR_W-1:0];
  assign instr_hi = head_bundle_i[fe_pkg::BUNDLE_W-1:fe_pkg::INSTR_W];
  assign opc_lo   = instr_lo[fe_pkg::OPC_W-1:0];

  // control transfer in lane 1 makes the upper word dead
  assign is_ctrl = (opc_lo == fe_pkg::OPC_BRANCH)
                 | (opc_lo == fe_pkg::OPC_JAL)
                 | (opc_lo == fe_pkg::OPC_JALR);

  // lane 1 word, fetch or exception view
  always_comb
  begin
    lane1 = '0;
    if (head_exc_v_i)
    begin
      lane1.exc.vaddr = head_pc_i;
      lane1.exc.code  = head_exc_code_i;
    end
    else
    begin
      lane1.fetch.pc    = head_pc_i;
      lane1.fetch.instr = instr_lo;
    end
  end

  // lane 2 word, always the fetch view at pc+4
  always_comb
  begin
    lane2             = '0;
    lane2.fetch.pc    = head_pc_i + fe_pkg::INSTR_BYTES;
    lane2.fetch.instr = instr_hi;
  end

  assign fe_queue1_o      = lane1;
  assign fe_queue1_type_o = head_exc_v_i ? fe_pkg::MSG_EXCEPTION : fe_pkg::MSG_FETCH;
  assign fe_queue1_v_o    = head_v_i;

  assign fe_queue2_o      = lane2;
  assign fe_queue2_type_o = fe_pkg::MSG_FETCH;
  // lane 2 only rides along with a valid fetch in lane 1
  assign fe_queue2_v_o    = head_v_i & ~head_exc_v_i & ~is_ctrl;

  // both lanes leave together; the head stays put while ready is low
  assign pop_o = head_v_i & fe_queue_ready_i;

endmodule

/* logic/fe_pc_gen.sv */
// commands are accepted only while no bus cycle is open; one read in flight at most
// a full buffer holds off new reads, so every response has room when it lands
module fe_pc_gen
  (
  input  logic                        clk_i,
  input  logic                        reset_i,
  // back end commands
  input  logic                        fe_cmd_v_i,
  input  logic [fe_pkg::CMD_W-1:0]    fe_cmd_op_i,
  input  logic [fe_pkg::VADDR_W-1:0]  fe_cmd_vaddr_i,
  output logic                        fe_cmd_yumi_o,
  // wishbone classic read master
  output logic                        wb_cyc_o,
  output logic                        wb_stb_o,
  output logic [fe_pkg::VADDR_W-1:0]  wb_adr_o,
  input  logic [fe_pkg::BUNDLE_W-1:0] wb_dat_i,
  input  logic                        wb_ack_i,
  input  logic                        wb_err_i,
  // fetch buffer side
  input  logic                        fifo_full_i,
  output logic                        push_v_o,
  output logic [fe_pkg::VADDR_W-1:0]  push_pc_o,
  output logic [fe_pkg::BUNDLE_W-1:0] push_bundle_o,
  output logic                        push_exc_v_o,
  output logic [fe_pkg::EXC_W-1:0]    push_exc_code_o,
  output logic                        flush_o
  );

  // run_r low is the wait state
  logic                       run_r;
  // busy_r marks the open bus cycle
  logic                       busy_r;
  logic [fe_pkg::VADDR_W-1:0] pc_r;

  logic cmd_acc;
  logic redirect_v;
  logic wait_v;
  logic misalign_v;
  logic resp_v;
  logic err_v;
  logic issue_v;

  // command handshake, held off while a read is open
  assign cmd_acc       = fe_cmd_v_i & ~busy_r;
  assign fe_cmd_yumi_o = cmd_acc;

  assign redirect_v = cmd_acc & (fe_cmd_op_i == fe_pkg::CMD_REDIRECT);
  assign wait_v     = cmd_acc & (fe_cmd_op_i == fe_pkg::CMD_WAIT);
  // target must sit on a bundle boundary
  assign misalign_v = redirect_v & (|fe_cmd_vaddr_i[fe_pkg::BUNDLE_OFF_W-1:0]);

  // bus response ends the cycle; err wins over ack
  assign resp_v = busy_r & (wb_ack_i | wb_err_i);
  assign err_v  = busy_r & wb_err_i;

  // new read once the previous one closed and the buffer has room
  assign issue_v = run_r & ~busy_r & ~fifo_full_i & ~cmd_acc;

  // cyc and stb track the open cycle, address held from pc_r
  assign wb_cyc_o = busy_r;
  assign wb_stb_o = busy_r;
  assign wb_adr_o = pc_r;

  // buffer push: bus response, or misaligned redirect reported right away
  assign push_v_o        = misalign_v | resp_v;
  assign push_pc_o       = misalign_v ? fe_cmd_vaddr_i : pc_r;
  assign push_bundle_o   = wb_dat_i;
  assign push_exc_v_o    = misalign_v | err_v;
  assign push_exc_code_o = misalign_v ? fe_pkg::EXC_MISALIGNED : fe_pkg::EXC_ACCESS_FAULT;

  // every accepted redirect drops what was buffered
  assign flush_o = redirect_v;

  always_ff @(posedge clk_i)
  begin
    if (reset_i)
    begin
      run_r  <= 1'b0;
      busy_r <= 1'b0;
      pc_r   <= '0;
    end
    else if (redirect_v)
    begin
      pc_r   <= fe_cmd_vaddr_i;
      // aligned target starts its first read immediately
      run_r  <= ~misalign_v;
      busy_r <= ~misalign_v;
    end
    else if (wait_v)
    begin
      run_r <= 1'b0;
    end
    else if (resp_v)
    begin
      busy_r <= 1'b0;
      if (err_v)
      begin
        // access fault parks fetch until the next redirect
        run_r <= 1'b0;
      end
      else
      begin
        pc_r <= pc_r + fe_pkg::BUNDLE_BYTES;
      end
    end
    else if (issue_v)
    begin
      busy_r <= 1'b1;
    end
  end

endmodule

/* logic/fe_pkg.sv */
// shared sizes, opcodes and lane word format for the fetch front end
// physical equals virtual; bundles are two 32-bit instructions, 8-byte aligned
package fe_pkg;

  // address and data widths
  localparam int VADDR_W  = 32;
  localparam int INSTR_W  = 32;
  localparam int BUNDLE_W = 2 * INSTR_W;

  // bundle stride and the low address bits that must be zero
  localparam logic [VADDR_W-1:0] BUNDLE_BYTES = 8;
  localparam logic [VADDR_W-1:0] INSTR_BYTES  = 4;
  localparam int BUNDLE_OFF_W = 3;

  // fetch buffer sizing
  localparam int FIFO_DEPTH = 4;
  localparam int FIFO_PTR_W = $clog2(FIFO_DEPTH);

  // risc-v major opcodes that transfer control
  localparam int OPC_W = 7;
  localparam logic [OPC_W-1:0] OPC_BRANCH = 7'b1100011;
  localparam logic [OPC_W-1:0] OPC_JAL    = 7'b1101111;
  localparam logic [OPC_W-1:0] OPC_JALR   = 7'b1100111;

  // back end command codes
  localparam int CMD_W = 2;
  localparam logic [CMD_W-1:0] CMD_REDIRECT = 2'd1;
  localparam logic [CMD_W-1:0] CMD_WAIT     = 2'd2;

  // lane message type
  localparam logic MSG_FETCH     = 1'b0;
  localparam logic MSG_EXCEPTION = 1'b1;

  // exception codes follow the risc-v mcause numbering
  localparam int EXC_W = 4;
  localparam logic [EXC_W-1:0] EXC_MISALIGNED   = 4'd0;
  localparam logic [EXC_W-1:0] EXC_ACCESS_FAULT = 4'd1;

  // one lane word
  localparam int QUEUE_W   = VADDR_W + INSTR_W;
  localparam int EXC_PAD_W = QUEUE_W - VADDR_W - EXC_W;

  // fetch view, pc in the upper half
  typedef struct packed {
    logic [VADDR_W-1:0] pc;
    logic [INSTR_W-1:0] instr;
  } fe_fetch_s;

  // exception view, faulting address then code, rest zero
  typedef struct packed {
    logic [VADDR_W-1:0]   vaddr;
    logic [EXC_W-1:0]     code;
    logic [EXC_PAD_W-1:0] pad;
  } fe_exc_s;

  // the lane type signal picks which view is meaningful
  typedef union packed {
    fe_fetch_s fetch;
    fe_exc_s   exc;
  } fe_queue_entry_u;

endpackage

/* logic/fe_top.sv */
// dual-lane fetch front end: command intake, wishbone reads, buffer, lane scanner
// no translation and no cache; the memory must answer every read with ack or err
module fe_top
  (
  input  logic                        clk_i,
  input  logic                        reset_i,
  // back end commands
  input  logic                        fe_cmd_v_i,
  input  logic [fe_pkg::CMD_W-1:0]    fe_cmd_op_i,
  input  logic [fe_pkg::VADDR_W-1:0]  fe_cmd_vaddr_i,
  output logic                        fe_cmd_yumi_o,
  // instruction memory
  output logic                        wb_cyc_o,
  output logic                        wb_stb_o,
  output logic [fe_pkg::VADDR_W-1:0]  wb_adr_o,
  input  logic [fe_pkg::BUNDLE_W-1:0] wb_dat_i,
  input  logic                        wb_ack_i,
  input  logic                        wb_err_i,
  // queue lanes to the back end
  output logic [fe_pkg::QUEUE_W-1:0]  fe_queue1_o,
  output logic                        fe_queue1_type_o,
  output logic                        fe_queue1_v_o,
  output logic [fe_pkg::QUEUE_W-1:0]  fe_queue2_o,
  output logic                        fe_queue2_type_o,
  output logic                        fe_queue2_v_o,
  input  logic                        fe_queue_ready_i
  );

  // fetch unit to buffer
  logic                        push_v;
  logic [fe_pkg::VADDR_W-1:0]  push_pc;
  logic [fe_pkg::BUNDLE_W-1:0] push_bundle;
  logic                        push_exc_v;
  logic [fe_pkg::EXC_W-1:0]    push_exc_code;
  logic                        fifo_full;
  logic                        flush;

  // buffer to scanner
  logic                        head_v;
  logic [fe_pkg::VADDR_W-1:0]  head_pc;
  logic [fe_pkg::BUNDLE_W-1:0] head_bundle;
  logic                        head_exc_v;
  logic [fe_pkg::EXC_W-1:0]    head_exc_code;
  logic                        pop;

  fe_pc_gen u_pc_gen
    (
    .clk_i           (clk_i),
    .reset_i         (reset_i),
    .fe_cmd_v_i      (fe_cmd_v_i),
    .fe_cmd_op_i     (fe_cmd_op_i),
    .fe_cmd_vaddr_i  (fe_cmd_vaddr_i),
    .fe_cmd_yumi_o   (fe_cmd_yumi_o),
    .wb_cyc_o        (wb_cyc_o),
    .wb_stb_o        (wb_stb_o),
    .wb_adr_o        (wb_adr_o),
    .wb_dat_i        (wb_dat_i),
    .wb_ack_i        (wb_ack_i),
    .wb_err_i        (wb_err_i),
    .fifo_full_i     (fifo_full),
    .push_v_o        (push_v),
    .push_pc_o       (push_pc),
    .push_bundle_o   (push_bundle),
    .push_exc_v_o    (push_exc_v),
    .push_exc_code_o (push_exc_code),
    .flush_o         (flush)
    );

  fe_fetch_fifo u_fetch_fifo
    (
    .clk_i           (clk_i),
    .reset_i         (reset_i),
    .flush_i         (flush),
    .push_v_i        (push_v),
    .push_pc_i       (push_pc),
    .push_bundle_i   (push_bundle),
    .push_exc_v_i    (push_exc_v),
    .push_exc_code_i (push_exc_code),
    .pop_i           (pop),
    .full_o          (fifo_full),
    .head_v_o        (head_v),
    .head_pc_o       (head_pc),
    .head_bundle_o   (head_bundle),
    .head_exc_v_o    (head_exc_v),
    .head_exc_code_o (head_exc_code)
    );

  fe_instr_scan u_instr_scan
    (
    .head_v_i         (head_v),
    .head_pc_i        (head_pc),
    .head_bundle_i    (head_bundle),
    .head_exc_v_i     (head_exc_v),
    .head_exc_code_i  (head_exc_code),
    .fe_queue_ready_i (fe_queue_ready_i),
    .pop_o            (pop),
    .fe_queue1_o      (fe_queue1_o),
    .fe_queue1_type_o (fe_queue1_type_o),
    .fe_queue1_v_o    (fe_queue1_v_o),
    .fe_queue2_o      (fe_queue2_o),
    .fe_queue2_type_o (fe_queue2_type_o),
    .fe_queue2_v_o    (fe_queue2_v_o)
    );

endmodule

/* run_sim.sh */
#!/bin/sh
# build and run the fetch front end testbench with verilator
set -e
cd "$(dirname "$0")"
verilator --binary --timing --timescale 1ns/1ps --top-module tb_fe_top -f sim.f -o tb_fe_top
./obj_dir/tb_fe_top > sim.log
cat sim.log
if grep -q "TB FAILED" sim.log; then
  echo "simulation failed"
  exit 1
fi
echo "simulation passed"

/* sim.f */
logic/fe_pkg.sv
logic/fe_pc_gen.sv
logic/fe_fetch_fifo.sv
logic/fe_instr_scan.sv
logic/fe_top.sv
dv/fe_imem_model.sv
dv/tb_fe_top.sv
